//--- vlane_isa_pkg.sv
// Operation and element-width encodings for one vector lane.
// Only the non-widening, low-half subset of the vector ISA is encoded.
// Encodings are local to this lane and do not follow any external opcode map.
`default_nettype none

package vlane_isa_pkg;

    typedef enum logic [4:0] {
        VADD   = 5'd0,   // vs2 + vs1
        VSUB   = 5'd1,   // vs2 - vs1
        VRSUB  = 5'd2,   // vs1 - vs2
        VSADDU = 5'd3,   // Unsigned saturating add
        VSADD  = 5'd4,   // Signed saturating add
        VSSUBU = 5'd5,
        VSSUB  = 5'd6,
        VMIN   = 5'd7,
        VMINU  = 5'd8,
        VMAX   = 5'd9,
        VMAXU  = 5'd10,
        VSLL   = 5'd11,  // Shift amount from low bits of vs1
        VSRL   = 5'd12,
        VSRA   = 5'd13,
        VAND   = 5'd14,
        VOR    = 5'd15,
        VXOR   = 5'd16,
        VMUL   = 5'd17,  // Low half of product
        VMACC  = 5'd18,  // vs1 * vs2 + vd_old
        VMADD  = 5'd19,  // vs1 * vd_old + vs2
        VID    = 5'd20   // Element index, uses lane position
    } vop_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

endpackage

`default_nettype wire

//--- vlane_data_pkg.sv
// Datapath widths and word types for one vector lane.
// The lane is fixed at 64 bits; the mask carries one bit per element
// at the smallest SEW, so wider SEWs use only the low mask bits.
`default_nettype none

package vlane_data_pkg;

    // Lane width in bits
    parameter int LANE_W = 64;

    // Elements per lane at SEW_8
    parameter int MAX_ELEMS = 8;

    // One packed lane word
    typedef logic [LANE_W-1:0] lane_word_t;

    // Bit i governs element i of the current SEW
    typedef logic [MAX_ELEMS-1:0] elem_mask_t;

endpackage

`default_nettype wire

//--- vlane_stage_if.sv
// Pipeline register bundle between two lane stages.
// Plain strobe with no ready signal. Fields are meaningful only while valid is high.
// prod holds the staged multiplicand on s1 and the product on s2.
`timescale 1ns/1ps
`default_nettype none

interface vlane_stage_if
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;
();

    logic       valid;
    vop_t       op;
    sew_t       sew;
    lane_word_t vs1;
    lane_word_t vs2;     // Also the VMADD addend
    lane_word_t vd_old;  // Old destination, for masking and VMACC
    logic       mask_en;
    elem_mask_t mask;
    lane_word_t prod;

    modport src (
        output valid, op, sew, vs1, vs2, vd_old, mask_en, mask, prod
    );

    modport dst (
        input valid, op, sew, vs1, vs2, vd_old, mask_en, mask, prod
    );

endinterface

`default_nettype wire

//--- vlane_operand_stage.sv
// Stage 1 of the lane pipeline.
// Registers the incoming instruction and stages the second multiplier
// operand in the prod slot, so stage 2 always computes vs1 * prod.
// Accepts one instruction per cycle; there is no back-pressure.
`timescale 1ns/1ps
`default_nettype none

module vlane_operand_stage
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       valid_i,
    input  vop_t       op_i,
    input  sew_t       sew_i,
    input  lane_word_t vs1_i,
    input  lane_word_t vs2_i,
    input  lane_word_t vd_old_i,
    input  logic       mask_en_i,
    input  elem_mask_t mask_i,
    vlane_stage_if.src out
);

    lane_word_t mul_b;

    // VMADD multiplies by vd_old and keeps vs2 as addend
    always_comb begin
        if (op_i == VMADD) begin
            mul_b = vd_old_i;
        end else begin
            mul_b = vs2_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= valid_i;
        end
    end

    // Instruction payload
    always_ff @(posedge clk_i) begin
        out.op      <= op_i;
        out.sew     <= sew_i;
        out.vs1     <= vs1_i;
        out.vs2     <= vs2_i;
        out.vd_old  <= vd_old_i;
        out.mask_en <= mask_en_i;
        out.mask    <= mask_i;
        out.prod    <= mul_b;  // Staged multiplicand
    end

endmodule

`default_nettype wire

//--- vlane_mul_stage.sv
// Stage 2 of the lane pipeline.
// Element-wise low-half multiply of vs1 by the staged multiplicand.
// Products are kept inside element boundaries for each SEW and, since
// only the low half is kept, signedness does not matter here.
// The product is formed for every instruction; stage 3 decides its use.
`timescale 1ns/1ps
`default_nettype none

module vlane_mul_stage
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    vlane_stage_if.dst in,
    vlane_stage_if.src out
);

    lane_word_t prod_by_sew [4];  // Indexed by SEW encoding
    lane_word_t prod_d;

    // One partitioned multiplier per element width
    for (genvar k = 0; k < 4; k++) begin : g_sew
        localparam int EW = 8 << k;
        localparam int NE = LANE_W / EW;

        for (genvar i = 0; i < NE; i++) begin : g_elem
            assign prod_by_sew[k][i*EW +: EW] = in.vs1[i*EW +: EW] * in.prod[i*EW +: EW];
        end
    end

    always_comb begin
        case (in.sew)
            SEW_8:   prod_d = prod_by_sew[0];
            SEW_16:  prod_d = prod_by_sew[1];
            SEW_32:  prod_d = prod_by_sew[2];
            default: prod_d = prod_by_sew[3];
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        out.op      <= in.op;
        out.sew     <= in.sew;
        out.vs1     <= in.vs1;
        out.vs2     <= in.vs2;  // VMADD addend rides along
        out.vd_old  <= in.vd_old;
        out.mask_en <= in.mask_en;
        out.mask    <= in.mask;
        out.prod    <= prod_d;
    end

endmodule

`default_nettype wire

//--- vlane_exec_stage.sv
// Stage 3 of the lane pipeline.
// Element-wise ALU, saturation, min/max, shifts, VID and multiply-add,
// followed by the per-element mask merge with vd_old.
// LANE_ID gives the lane position for VID; element index is
// LANE_ID * (64/SEW) + i, truncated to the element width.
`timescale 1ns/1ps
`default_nettype none

module vlane_exec_stage
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  logic       clk_i,
    input  logic       reset_i,
    vlane_stage_if.dst in,
    output logic       valid_o,
    output lane_word_t vd_o
);

    // Operands are zero-extended elements; result is cut to ew bits
    function automatic lane_word_t elem_calc(
        input vop_t        op,
        input int unsigned ew,
        input lane_word_t  a,
        input lane_word_t  b,
        input lane_word_t  p,
        input lane_word_t  c,
        input lane_word_t  vid
    );
        lane_word_t              emask;
        lane_word_t              r;
        logic signed [LANE_W+1:0] sa;
        logic signed [LANE_W+1:0] sb;
        logic signed [LANE_W+1:0] smax;
        logic signed [LANE_W+1:0] smin;
        logic signed [LANE_W+1:0] ssum;
        logic [LANE_W+1:0]        usum;
        int unsigned              sh;

        emask = {LANE_W{1'b1}} >> (LANE_W - ew);
        sa    = $signed({2'b00, a} << (LANE_W + 2 - ew)) >>> (LANE_W + 2 - ew);
        sb    = $signed({2'b00, b} << (LANE_W + 2 - ew)) >>> (LANE_W + 2 - ew);
        smax  = $signed({2'b00, emask >> 1});
        smin  = -smax - 1;
        sh    = int'(a[5:0]) & (ew - 1);  // Only log2(SEW) bits count
        usum  = '0;
        ssum  = '0;
        r     = '0;

        case (op)
            VADD:  r = b + a;
            VSUB:  r = b - a;
            VRSUB: r = a - b;
            VSADDU: begin
                usum = {2'b00, b} + {2'b00, a};
                r    = (usum > {2'b00, emask}) ? emask : usum[LANE_W-1:0];
            end
            VSSUBU: r = (a > b) ? '0 : b - a;  // Clamp at zero
            VSADD, VSSUB: begin
                ssum = (op == VSADD) ? sb + sa : sb - sa;
                if (ssum > smax) begin
                    r = smax[LANE_W-1:0];
                end else if (ssum < smin) begin
                    r = smin[LANE_W-1:0];
                end else begin
                    r = ssum[LANE_W-1:0];
                end
            end
            VMIN:  r = (sb < sa) ? b : a;
            VMINU: r = (b < a) ? b : a;
            VMAX:  r = (sb > sa) ? b : a;
            VMAXU: r = (b > a) ? b : a;
            VSLL:  r = b << sh;
            VSRL:  r = b >> sh;  // b is zero-extended
            VSRA:  r = lane_word_t'(sb >>> sh);
            VAND:  r = a & b;
            VOR:   r = a | b;
            VXOR:  r = a ^ b;
            VMUL:  r = p;
            VMACC: r = p + c;
            VMADD: r = p + b;  // b holds the staged addend
            VID:   r = vid;
            default: r = '0;
        endcase

        return r & emask;
    endfunction

    lane_word_t res_by_sew [4];  // Masked result per SEW
    lane_word_t res_d;

    for (genvar k = 0; k < 4; k++) begin : g_sew
        localparam int EW = 8 << k;
        localparam int NE = LANE_W / EW;

        for (genvar i = 0; i < NE; i++) begin : g_elem
            logic [EW-1:0] old_e;
            logic [EW-1:0] r_e;

            assign old_e = in.vd_old[i*EW +: EW];
            assign r_e   = EW'(elem_calc(in.op, EW,
                                         lane_word_t'(in.vs1[i*EW +: EW]),
                                         lane_word_t'(in.vs2[i*EW +: EW]),
                                         lane_word_t'(in.prod[i*EW +: EW]),
                                         lane_word_t'(old_e),
                                         lane_word_t'(LANE_ID * NE + i)));

            // Disabled elements keep the old destination
            assign res_by_sew[k][i*EW +: EW] = (in.mask_en && !in.mask[i]) ? old_e : r_e;
        end
    end

    always_comb begin
        case (in.sew)
            SEW_8:   res_d = res_by_sew[0];
            SEW_16:  res_d = res_by_sew[1];
            SEW_32:  res_d = res_by_sew[2];
            default: res_d = res_by_sew[3];
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= in.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        vd_o <= res_d;  // Meaningful only with valid_o
    end

endmodule

`default_nettype wire

//--- vlane_top.sv
// One 64-bit lane of the vector execution unit.
// Three pipeline stages. The result and valid_o appear three clock edges after
// valid_i is sampled. A new instruction may enter every cycle and there is
// no back-pressure, so the consumer must take every result.
// LANE_ID is the lane position used by VID.
`timescale 1ns/1ps
`default_nettype none

module vlane_top
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       valid_i,
    input  vop_t       op_i,
    input  sew_t       sew_i,
    input  lane_word_t vs1_i,
    input  lane_word_t vs2_i,
    input  lane_word_t vd_old_i,
    input  logic       mask_en_i,
    input  elem_mask_t mask_i,
    output logic       valid_o,
    output lane_word_t vd_o
);

    vlane_stage_if s1 ();  // Operand stage to mul stage
    vlane_stage_if s2 ();  // Mul stage to exec stage

    vlane_operand_stage i_operand (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (valid_i),
        .op_i      (op_i),
        .sew_i     (sew_i),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .vd_old_i  (vd_old_i),
        .mask_en_i (mask_en_i),
        .mask_i    (mask_i),
        .out       (s1.src)
    );

    vlane_mul_stage i_mul (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .in      (s1.dst),
        .out     (s2.src)
    );

    vlane_exec_stage #(
        .LANE_ID (LANE_ID)
    ) i_exec (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .in      (s2.dst),
        .valid_o (valid_o),
        .vd_o    (vd_o)
    );

endmodule

`default_nettype wire

//--- vlane_props.sv
// Timing properties of the lane, bound into every vlane_top instance.
// Latency is fixed at three cycles; checks pause for three cycles
// after reset, since the pipeline is flushed then.
`timescale 1ns/1ps
`default_nettype none

module vlane_props
    import vlane_data_pkg::*;
(
    input logic       clk_i,
    input logic       reset_i,
    input logic       valid_i,
    input logic       valid_o,
    input lane_word_t vd_o
);

    // Pipeline comes out of reset empty
    assert property (@(posedge clk_i) reset_i |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

    assert property (@(posedge clk_i)
        (!reset_i && !$past(reset_i, 1) && !$past(reset_i, 2) && !$past(reset_i, 3))
        |-> (valid_o == $past(valid_i, 3)))
        else $error("valid_o does not follow valid_i by three cycles");

    assert property (@(posedge clk_i) disable iff (reset_i) valid_o |-> !$isunknown(vd_o))
        else $error("vd_o unknown while valid_o is high");

endmodule

bind vlane_top vlane_props i_props (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .vd_o    (vd_o)
);

`default_nettype wire

//--- tb_vlane.sv
// Directed testbench for one vector lane, DUT built with LANE_ID = 3.
// Expected results come from an element-wise model of the lane rules and
// wait in a queue with the cycle they are due, so both data and the
// three-cycle latency are checked. Needs a simulator with timing support.
`timescale 1ns/1ps
`default_nettype none

module tb_vlane
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;
();

    localparam int LANE_POS       = 3;
    localparam int OPS_PER_TEST   = 64;
    localparam int TIMEOUT_CYCLES = 6 * OPS_PER_TEST * 4 + 464;  // 2000 cycles

    logic       clk_i;
    logic       reset_i;
    logic       valid_i;
    vop_t       op_i;
    sew_t       sew_i;
    lane_word_t vs1_i;
    lane_word_t vs2_i;
    lane_word_t vd_old_i;
    logic       mask_en_i;
    elem_mask_t mask_i;
    logic       valid_o;
    lane_word_t vd_o;

    lane_word_t exp_data [$];
    int         exp_due  [$];  // Cycle at which each result must show
    int         cycle_cnt = 0;
    int         checks    = 0;
    int         errors    = 0;
    logic       due_now;
    lane_word_t want;

    vlane_top #(
        .LANE_ID (LANE_POS)
    ) i_dut (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (valid_i),
        .op_i      (op_i),
        .sew_i     (sew_i),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .vd_old_i  (vd_old_i),
        .mask_en_i (mask_en_i),
        .mask_i    (mask_i),
        .valid_o   (valid_o),
        .vd_o      (vd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic lane_word_t elem_ones(int ew);
        return (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    endfunction

    function automatic logic signed [65:0] sext(lane_word_t x, int ew);
        logic signed [65:0] v;
        v = $signed({2'b00, x});
        if (x[ew-1]) begin
            v = v - (66'sd1 <<< ew);
        end
        return v;
    endfunction

    // Lane rules per element followed by the mask merge
    function automatic lane_word_t model(vop_t op, sew_t sew, lane_word_t a, lane_word_t b,
                                         lane_word_t c, logic men, elem_mask_t msk);
        int                 ew;
        int                 ne;
        int                 sh;
        lane_word_t         m;
        lane_word_t         ae;
        lane_word_t         be;
        lane_word_t         ce;
        lane_word_t         re;
        lane_word_t         res;
        logic signed [65:0] sa;
        logic signed [65:0] sb;
        logic signed [65:0] sr;
        logic signed [65:0] smax;
        logic signed [65:0] smin;
        logic [65:0]        ur;

        ew   = 8 << int'(sew);
        ne   = 64 / ew;
        m    = elem_ones(ew);
        smax = (66'sd1 <<< (ew - 1)) - 66'sd1;
        smin = -smax - 66'sd1;
        res  = '0;
        for (int i = 0; i < ne; i++) begin
            ae = (a >> (i * ew)) & m;
            be = (b >> (i * ew)) & m;
            ce = (c >> (i * ew)) & m;
            sa = sext(ae, ew);
            sb = sext(be, ew);
            sh = int'(ae[5:0]) % ew;  // Low log2(SEW) bits
            case (op)
                VADD:   re = be + ae;
                VSUB:   re = be - ae;
                VRSUB:  re = ae - be;
                VSADDU: begin
                    ur = {2'b00, be} + {2'b00, ae};
                    re = (ur > {2'b00, m}) ? m : ur[63:0];
                end
                VSSUBU: re = (ae > be) ? 64'd0 : be - ae;
                VSADD, VSSUB: begin
                    sr = (op == VSADD) ? sb + sa : sb - sa;
                    if (sr > smax) begin
                        sr = smax;
                    end else if (sr < smin) begin
                        sr = smin;
                    end
                    re = sr[63:0];
                end
                VMIN:   re = (sb < sa) ? be : ae;
                VMINU:  re = (be < ae) ? be : ae;
                VMAX:   re = (sb > sa) ? be : ae;
                VMAXU:  re = (be > ae) ? be : ae;
                VSLL:   re = be << sh;
                VSRL:   re = be >> sh;
                VSRA: begin
                    sr = sb >>> sh;
                    re = sr[63:0];
                end
                VAND:   re = ae & be;
                VOR:    re = ae | be;
                VXOR:   re = ae ^ be;
                VMUL:   re = ae * be;
                VMACC:  re = ae * be + ce;
                VMADD:  re = ae * ce + be;
                VID:    re = 64'(LANE_POS * ne + i);
                default: re = '0;
            endcase
            if (men && !msk[i]) begin
                re = ce;  // Disabled element keeps vd_old
            end
            res = res | ((re & m) << (i * ew));
        end
        return res;
    endfunction

    function automatic lane_word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // Each element picks zero, one, -1, signed max, signed min or random
    function automatic lane_word_t corner_word(sew_t sew);
        int         ew;
        lane_word_t m;
        lane_word_t e;
        lane_word_t w;

        ew = 8 << int'(sew);
        m  = elem_ones(ew);
        w  = '0;
        for (int i = 0; i < 64 / ew; i++) begin
            case ($urandom % 6)
                0:       e = '0;
                1:       e = 64'd1;
                2:       e = m;
                3:       e = m >> 1;
                4:       e = m ^ (m >> 1);
                default: e = rand_word() & m;
            endcase
            w = w | ((e & m) << (i * ew));
        end
        return w;
    endfunction

    task automatic check_word(string name, lane_word_t act, lane_word_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
        end
    endtask

    task automatic check_valid(logic act, logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] valid_o: got 0x%h, expected 0x%h", act, exp);
        end
    endtask

    task automatic issue_op(vop_t op, sew_t sew, lane_word_t a, lane_word_t b,
                            lane_word_t c, logic men, elem_mask_t msk);
        @(posedge clk_i);
        valid_i   <= 1'b1;
        op_i      <= op;
        sew_i     <= sew;
        vs1_i     <= a;
        vs2_i     <= b;
        vd_old_i  <= c;
        mask_en_i <= men;
        mask_i    <= msk;
        exp_data.push_back(model(op, sew, a, b, c, men, msk));
        exp_due.push_back(cycle_cnt + 4);  // Due three edges after this issue edge
    endtask

    task automatic drain_pipe();
        @(posedge clk_i);
        valid_i <= 1'b0;
        while (exp_due.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    task automatic finish_test(string name, int errs_at_start);
        drain_pipe();
        $display("%s: %0d errors", name, errors - errs_at_start);
    endtask

    // Outputs are sampled mid-cycle where they are stable
    always @(negedge clk_i) begin
        if (!reset_i) begin
            due_now = (exp_due.size() != 0) && (exp_due[0] == cycle_cnt);
            check_valid(valid_o, due_now);
            if (due_now) begin
                want = exp_data.pop_front();
                void'(exp_due.pop_front());
                if (valid_o) begin
                    check_word("vd_o", vd_o, want);
                end
            end
        end
    end

    task automatic add_sub_test();
        int start;
        start = errors;
        for (int n = 0; n < OPS_PER_TEST; n++) begin
            issue_op(vop_t'(5'(int'(VADD) + n % 3)), sew_t'(2'((n / 3) % 4)),
                     rand_word(), rand_word(), rand_word(), 1'b0, '0);
        end
        finish_test("Test 1 add/sub", start);
    endtask

    task automatic saturate_minmax_test();
        int   start;
        sew_t sew;
        start = errors;
        for (int n = 0; n < OPS_PER_TEST; n++) begin
            sew = sew_t'(2'((n / 8) % 4));
            issue_op(vop_t'(5'(int'(VSADDU) + n % 8)), sew,
                     corner_word(sew), corner_word(sew), rand_word(), 1'b0, '0);
        end
        finish_test("Test 2 saturate/min/max", start);
    endtask

    task automatic shift_logic_test();
        int start;
        start = errors;
        for (int n = 0; n < OPS_PER_TEST; n++) begin
            issue_op(vop_t'(5'(int'(VSLL) + n % 6)), sew_t'(2'((n / 6) % 4)),
                     rand_word(), rand_word(), rand_word(), 1'b0, '0);
        end
        finish_test("Test 3 shift/logic", start);
    endtask

    task automatic multiply_test();
        int start;
        start = errors;
        for (int n = 0; n < OPS_PER_TEST; n++) begin
            issue_op(vop_t'(5'(int'(VMUL) + n % 3)), sew_t'(2'((n / 3) % 4)),
                     rand_word(), rand_word(), rand_word(), 1'b0, '0);
        end
        finish_test("Test 4 multiply/accumulate", start);
    endtask

    task automatic vid_mask_test();
        int start;
        start = errors;
        for (int s = 0; s < 4; s++) begin
            issue_op(VID, sew_t'(2'(s)), rand_word(), rand_word(), rand_word(), 1'b0, '0);
        end
        for (int n = 4; n < OPS_PER_TEST; n++) begin
            issue_op(vop_t'(5'($urandom % 21)), sew_t'(2'($urandom % 4)),
                     rand_word(), rand_word(), rand_word(), 1'b1, elem_mask_t'($urandom));
        end
        finish_test("Test 5 VID/masking", start);
    endtask

    // valid_i stays high for the whole stream
    task automatic throughput_test();
        int start;
        start = errors;
        for (int n = 0; n < OPS_PER_TEST; n++) begin
            issue_op(vop_t'(5'($urandom % 21)), sew_t'(2'($urandom % 4)),
                     rand_word(), rand_word(), rand_word(),
                     1'($urandom % 2), elem_mask_t'($urandom));
        end
        finish_test("Test 6 throughput", start);
    endtask

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: no end of test after %0d cycles", cycle_cnt);
        $display("Something failed");
        $finish;
    end

    initial begin
        reset_i   = 1'b1;
        valid_i   = 1'b0;
        op_i      = VADD;
        sew_i     = SEW_8;
        vs1_i     = '0;
        vs2_i     = '0;
        vd_old_i  = '0;
        mask_en_i = 1'b0;
        mask_i    = '0;
        void'($urandom(15090));
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;

        add_sub_test();
        saturate_minmax_test();
        shift_logic_test();
        multiply_test();
        vid_mask_test();
        throughput_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
vlane_isa_pkg.sv
vlane_data_pkg.sv
vlane_stage_if.sv
vlane_operand_stage.sv
vlane_mul_stage.sv
vlane_exec_stage.sv
vlane_top.sv
vlane_props.sv
tb_vlane.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; the exit status follows the testbench result
verilator --binary --timing --assert --top-module tb_vlane -f vlog.f -o tb_vlane_sim \
    && ./obj_dir/tb_vlane_sim | tee /dev/stderr | grep "Everything OK" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
